// ==== coreSequencer.sv ====
`default_nettype none

module coreSequencer #(
    parameter tenyrPkg::word_t resetVector = 32'h1000
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   haltReq_i,
    input  logic                   errI_i,
    input  logic                   errD_i,
    input  logic                   rtyI_i,
    input  logic                   rtyD_i,
    input  logic                   ackI_i,
    input  tenyrPkg::word_t        datI_i,
    input  logic                   ackD_i,
    input  tenyrPkg::word_t        datD_i,
    input  tenyrPkg::decodedInsn_t decoded_i,
    input  tenyrPkg::word_t        valZ_i,
    input  logic                   execDone_i,
    input  tenyrPkg::word_t        execResult_i,
    output tenyrPkg::word_t        adrI_o,
    output logic                   stbI_o,
    output tenyrPkg::word_t        insn_o,
    output tenyrPkg::word_t        nextPc_o,
    output logic                   execStart_o,
    output tenyrPkg::dataBus_t     dataBus_o,
    output logic                   regWriteEn_o,
    output tenyrPkg::regIdx_t      regWriteIdx_o,
    output tenyrPkg::word_t        regWriteData_o,
    output logic                   halt_o
);
    import tenyrPkg::*;

    coreState_e state;
    word_t      pc;
    word_t      nextPc;
    word_t      insn;
    word_t      computed;   // op(A,B) + C
    word_t      loadData;
    word_t      wbValue;
    logic       haltLatched;
    logic       busFault;
    logic       stall;
    logic       memAccess;

    assign busFault  = errI_i | errD_i | rtyI_i | rtyD_i;
    assign halt_o    = busFault | haltLatched;
    assign stall     = haltReq_i | halt_o;
    assign memAccess = decoded_i.loading | decoded_i.storing;
    assign wbValue   = decoded_i.loading ? loadData : computed;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= stFetch;
            pc          <= resetVector;
            haltLatched <= 1'b0;
        end else begin
            if (busFault) haltLatched <= 1'b1;
            case (state)
                stIssue:     if (!stall) state <= stExecute;
                stExecute:   if (execDone_i) state <= stMemSetup;
                stMemSetup:  state <= memAccess ? stMemWait : stWriteBack;
                stMemWait: begin
                    if (ackD_i) state <= stWriteBack;
                    else if (busFault) state <= stIssue;   // park, halt holds it
                end
                stWriteBack: begin
                    state <= stFetch;
                    pc    <= decoded_i.branching ? wbValue : nextPc;
                end
                stFetch: begin
                    if (ackI_i) state <= stLatch;
                    else if (busFault) state <= stIssue;
                end
                stLatch:     state <= stIssue;   // decode and reg reads settle
                default:     state <= stFetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        nextPc <= pc + 32'sd1;
        if (state == stFetch && ackI_i) insn <= datI_i;
        if (state == stExecute && execDone_i) computed <= execResult_i;
        if (state == stMemWait && ackD_i) loadData <= datD_i;
    end

    always_comb begin
        dataBus_o.adr = decoded_i.derefRhs ? computed : valZ_i;
        dataBus_o.dat = decoded_i.derefRhs ? valZ_i : computed;
        dataBus_o.stb = (state == stMemWait);
        dataBus_o.wen = (state == stMemWait) && decoded_i.storing;
    end

    assign adrI_o         = pc;
    assign stbI_o         = (state == stFetch);
    assign insn_o         = insn;
    assign nextPc_o       = nextPc;
    assign execStart_o    = (state == stIssue) && !stall;
    assign regWriteEn_o   = (state == stWriteBack) && !decoded_i.storing;
    assign regWriteIdx_o  = decoded_i.z;
    assign regWriteData_o = wbValue;

    assert property (@(posedge clk) disable iff (reset)
        dataBus_o.stb |-> (decoded_i.loading || decoded_i.storing));

    assert property (@(posedge clk) disable iff (reset) !(stbI_o && dataBus_o.stb));

endmodule

`default_nettype wire

// ==== cpuCore.f ====
tenyrPkg.sv
regFile.sv
insnDecode.sv
execUnit.sv
coreSequencer.sv
cpuCore.sv
tbCpuCore.sv

// ==== cpuCore.sv ====
`default_nettype none

module cpuCore #(
    parameter tenyrPkg::word_t resetVector = 32'h1000
) (
    input  logic            clk,
    input  logic            reset,
    output tenyrPkg::word_t adrI_o,
    output logic            stbI_o,
    output logic            cycI_o,
    input  tenyrPkg::word_t datI_i,
    input  logic            ackI_i,
    input  logic            errI_i,
    input  logic            rtyI_i,
    output tenyrPkg::word_t adrD_o,
    output tenyrPkg::word_t datD_o,
    output logic            wenD_o,
    output logic            stbD_o,
    output logic            cycD_o,
    input  tenyrPkg::word_t datD_i,
    input  logic            ackD_i,
    input  logic            errD_i,
    input  logic            rtyD_i,
    input  logic            haltReq_i,
    output logic            halt_o
);
    import tenyrPkg::*;

    word_t        insn;
    word_t        nextPc;
    word_t        valX;
    word_t        valY;
    word_t        valZ;
    decodedInsn_t decoded;
    operands_t    operands;
    logic         execStart;
    logic         execDone;
    word_t        execResult;
    dataBus_t     dataBus;
    logic         regWriteEn;
    regIdx_t      regWriteIdx;
    word_t        regWriteData;

    regFile uRegFile (
        .clk         (clk),
        .writeEn_i   (regWriteEn),
        .writeIdx_i  (regWriteIdx),
        .writeData_i (regWriteData),
        .idxX_i      (decoded.x),
        .idxY_i      (decoded.y),
        .idxZ_i      (decoded.z),
        .nextPc_i    (nextPc),
        .valX_o      (valX),
        .valY_o      (valY),
        .valZ_o      (valZ)
    );

    insnDecode uDecode (
        .insn_i     (insn),
        .valX_i     (valX),
        .valY_i     (valY),
        .decoded_o  (decoded),
        .operands_o (operands)
    );

    execUnit uExec (
        .clk        (clk),
        .reset      (reset),
        .start_i    (execStart),
        .op_i       (decoded.op),
        .operands_i (operands),
        .done_o     (execDone),
        .result_o   (execResult)
    );

    coreSequencer #(
        .resetVector (resetVector)
    ) uSequencer (
        .clk            (clk),
        .reset          (reset),
        .haltReq_i      (haltReq_i),
        .errI_i         (errI_i),
        .errD_i         (errD_i),
        .rtyI_i         (rtyI_i),
        .rtyD_i         (rtyD_i),
        .ackI_i         (ackI_i),
        .datI_i         (datI_i),
        .ackD_i         (ackD_i),
        .datD_i         (datD_i),
        .decoded_i      (decoded),
        .valZ_i         (valZ),
        .execDone_i     (execDone),
        .execResult_i   (execResult),
        .adrI_o         (adrI_o),
        .stbI_o         (stbI_o),
        .insn_o         (insn),
        .nextPc_o       (nextPc),
        .execStart_o    (execStart),
        .dataBus_o      (dataBus),
        .regWriteEn_o   (regWriteEn),
        .regWriteIdx_o  (regWriteIdx),
        .regWriteData_o (regWriteData),
        .halt_o         (halt_o)
    );

    assign cycI_o = stbI_o;
    assign adrD_o = dataBus.adr;
    assign datD_o = dataBus.dat;
    assign wenD_o = dataBus.wen;
    assign stbD_o = dataBus.stb;
    assign cycD_o = dataBus.stb;

endmodule

`default_nettype wire

// ==== cpuStim.txt ====
// header: program words, data image pairs, expected stores (all hex)
// then program at 0x1000, image (address data), stores (address data), halt address
23 2 17
// r1 = -6, r2 = 5, r13 = 0x200
C10FFFFA C2000005 CD000200
// sixteen operations over kinds 0 to 2, each stored to [r13]
2D120010 6D1210FF AD21200F 6D103001 2D124064 AD1257FF 6D206005 2D127002
AD2080F0 2D129010 6D20AABC 6D12B004 AD12C064 2D22D003 6D12E002 AD10FFFF
// kind 3 add, loads, store to [rhs]
ED212345 33000100 2D300000 C4000101 F5400000 D5400001 F6400001 2D600000
// jump over a bad store, count-down loop, halt loop
CFF00001 2D000BAD C7000003 2D700000 C77FFFFF 08077000 4F8F1FFC CFFFFFFF
// data image
00000100 13579BDF 00000101 2468ACE0
// expected stores
00000200 0000000F 00000200 000000FF 00000200 00000004 00000200 FFFFFFFD
00000200 00000063 00000200 FFFFD00B 00000200 FFFFFFFF 00000200 00000001
00000200 FFFFFFFA 00000200 0000000A 00000200 00005ABC 00000200 10000004
00000200 0000006F 00000200 000000A3 00000200 00000005 00000200 FFFFFFFF
00000200 0001234A 00000200 13579BDF 00000102 2468ACE0 00000200 2468ACE0
00000200 00000003 00000200 00000002 00000200 00000001
// halt address
00001022

// ==== execUnit.sv ====
`default_nettype none

module execUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                start_i,
    input  tenyrPkg::aluOp_e    op_i,
    input  tenyrPkg::operands_t operands_i,
    output logic                done_o,
    output tenyrPkg::word_t     result_o
);
    import tenyrPkg::*;

    aluOp_e    opR;
    operands_t opnd;      // stage 1
    word_t     opA;
    word_t     opB;
    word_t     aluResult;
    word_t     partial;   // stage 2
    word_t     addendC;
    logic      valid1;
    logic      valid2;

    assign opA = opnd.a;
    assign opB = opnd.b;

    always_comb begin
        case (opR)
            opOr:    aluResult = opA | opB;
            opAnd:   aluResult = opA & opB;
            opXor:   aluResult = opA ^ opB;
            opSra:   aluResult = opA >>> opB;
            opAdd:   aluResult = opA + opB;
            opMul:   aluResult = opA * opB;
            opEq:    aluResult = (opA == opB) ? '1 : '0;
            opLt:    aluResult = (opA < opB) ? '1 : '0;
            opOrn:   aluResult = opA | ~opB;
            opAndn:  aluResult = opA & ~opB;
            opPack:  aluResult = {opA[19:0], opB[11:0]};
            opSrl:   aluResult = opA >> opB;
            opSub:   aluResult = opA - opB;
            opShl:   aluResult = opA << opB;
            opTest:  aluResult = ((opA & (32'sd1 << opB)) != 0) ? '1 : '0;
            default: aluResult = (opA >= opB) ? '1 : '0;   // opGe
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            done_o <= 1'b0;
        end else begin
            valid1 <= start_i;
            valid2 <= valid1;
            done_o <= valid2;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            opR  <= op_i;
            opnd <= operands_i;
        end
        if (valid1) begin
            partial <= aluResult;
            addendC <= opnd.c;
        end
        if (valid2) begin
            result_o <= partial + addendC;
        end
    end

    assert property (@(posedge clk) disable iff (reset) start_i |-> ##3 done_o);

endmodule

`default_nettype wire

// ==== insnDecode.sv ====
`default_nettype none

module insnDecode (
    input  tenyrPkg::word_t        insn_i,
    input  tenyrPkg::word_t        valX_i,
    input  tenyrPkg::word_t        valY_i,
    output tenyrPkg::decodedInsn_t decoded_o,
    output tenyrPkg::operands_t    operands_o
);
    import tenyrPkg::*;

    insnKind_e   kind;
    logic [1:0]  derefBits;
    logic [19:0] immField;
    word_t       imm;

    assign kind      = insnKind_e'(insn_i[31:30]);
    assign derefBits = insn_i[29:28];
    assign immField  = insn_i[19:0];

    always_comb begin
        decoded_o.kind = kind;
        decoded_o.z    = insn_i[27:24];
        decoded_o.x    = insn_i[23:20];
        if (kind == kindZeroXI) begin
            decoded_o.y  = '0;
            decoded_o.op = opOr;   // y and op bits hold immediate
            imm          = {{12{immField[19]}}, immField};
        end else begin
            decoded_o.y  = immField[19:16];
            decoded_o.op = aluOp_e'(immField[15:12]);
            imm          = {{20{immField[11]}}, immField[11:0]};
        end
        decoded_o.imm = imm;

        // 00 plain, 01 store to [rhs], 10 store to [Z], 11 load
        decoded_o.storing   = ^derefBits;
        decoded_o.loading   = &derefBits;
        decoded_o.derefRhs  = derefBits[0];
        decoded_o.branching = (&insn_i[27:24]) && !(^derefBits);
    end

    always_comb begin
        case (kind)
            kindXYI: begin
                operands_o = {valX_i, valY_i, imm};   // a, b, c
            end
            kindXIY: begin
                operands_o = {valX_i, imm, valY_i};
            end
            kindIXY: begin
                operands_o = {imm, valX_i, valY_i};
            end
            default: begin
                operands_o = {32'h0, valX_i, imm};
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile (
    input  logic              clk,
    input  logic              writeEn_i,
    input  tenyrPkg::regIdx_t writeIdx_i,
    input  tenyrPkg::word_t   writeData_i,
    input  tenyrPkg::regIdx_t idxX_i,
    input  tenyrPkg::regIdx_t idxY_i,
    input  tenyrPkg::regIdx_t idxZ_i,
    input  tenyrPkg::word_t   nextPc_i,
    output tenyrPkg::word_t   valX_o,
    output tenyrPkg::word_t   valY_o,
    output tenyrPkg::word_t   valZ_o
);
    import tenyrPkg::*;

    word_t regs [0:14];

    initial begin
        for (int k = 0; k < 15; k++) begin
            regs[k] = '0;
        end
    end

    assign valX_o = (&idxX_i) ? nextPc_i : regs[idxX_i];
    assign valY_o = (&idxY_i) ? nextPc_i : regs[idxY_i];
    assign valZ_o = (&idxZ_i) ? nextPc_i : regs[idxZ_i];

    always_ff @(posedge clk) begin
        if (writeEn_i && (|writeIdx_i) && !(&writeIdx_i)) begin   // skip r0 and pc
            regs[writeIdx_i] <= writeData_i;
        end
    end

    assert property (@(posedge clk) (idxX_i == '0) |-> (valX_o == '0));

endmodule

`default_nettype wire

// ==== tbCpuCore.sv ====
`default_nettype none

module tbCpuCore;
    timeunit 1ns;
    timeprecision 100ps;

    import tenyrPkg::*;

    localparam word_t resetVector = 32'h1000;
    localparam int    clkPeriod   = 100;
    localparam int    maxWait     = 3;   // extra cycles before an ack

    logic  clk;
    logic  reset;
    word_t adrI_o;
    logic  stbI_o;
    logic  cycI_o;
    word_t datI_i;
    logic  ackI_i;
    logic  errI_i;
    logic  rtyI_i;
    word_t adrD_o;
    word_t datD_o;
    logic  wenD_o;
    logic  stbD_o;
    logic  cycD_o;
    word_t datD_i;
    logic  ackD_i;
    logic  errD_i;
    logic  rtyD_i;
    logic  haltReq_i;
    logic  halt_o;

    word_t stim [0:255];
    word_t imem [0:255];
    word_t dmem [0:1023];
    int    progLen;
    int    imageLen;
    int    storeTotal;
    int    storeBase;
    int    storeCount;
    int    errorCount;
    int    checkCount;
    int    watchdogCycles;
    int    fetchWait;
    int    dataWait;
    logic  fetchBusy;
    logic  dataBusy;
    logic  stimLoaded;

    cpuCore #(
        .resetVector (resetVector)
    ) uut (
        .clk       (clk),
        .reset     (reset),
        .adrI_o    (adrI_o),
        .stbI_o    (stbI_o),
        .cycI_o    (cycI_o),
        .datI_i    (datI_i),
        .ackI_i    (ackI_i),
        .errI_i    (errI_i),
        .rtyI_i    (rtyI_i),
        .adrD_o    (adrD_o),
        .datD_o    (datD_o),
        .wenD_o    (wenD_o),
        .stbD_o    (stbD_o),
        .cycD_o    (cycD_o),
        .datD_i    (datD_i),
        .ackD_i    (ackD_i),
        .errD_i    (errD_i),
        .rtyD_i    (rtyD_i),
        .haltReq_i (haltReq_i),
        .halt_o    (halt_o)
    );

    task automatic checkStore(input string name, input word_t expAdr, input word_t expDat,
                              input word_t actAdr, input word_t actDat);
        checkCount++;
        if (actAdr !== expAdr || actDat !== expDat) begin
            errorCount++;
            $display("[FAIL] %s: expected [%h] <- %h, actual [%h] <- %h",
                     name, expAdr, expDat, actAdr, actDat);
        end
    endtask

    task automatic checkPc(input string name, input word_t expPc, input word_t actPc);
        checkCount++;
        if (actPc !== expPc) begin
            errorCount++;
            $display("[FAIL] %s: expected %h, actual %h", name, expPc, actPc);
        end
    endtask

    task automatic checkFlag(input string name, input logic expBit, input logic actBit);
        checkCount++;
        if (actBit !== expBit) begin
            errorCount++;
            $display("[FAIL] %s: expected %b, actual %b", name, expBit, actBit);
        end
    endtask

    task automatic loadStim();
        int    k;
        int    imageBase;
        word_t adr;
        $readmemh("cpuStim.txt", stim);
        progLen    = stim[0];
        imageLen   = stim[1];
        storeTotal = stim[2];
        imageBase  = 3 + progLen;
        storeBase  = imageBase + 2 * imageLen;
        watchdogCycles = progLen * 20 * (maxWait + 1) + 200;
        for (k = 0; k < 1024; k++) begin
            dmem[k] = 32'hdead0000 ^ k;   // unwritten words
        end
        for (k = 0; k < progLen; k++) begin
            imem[k] = stim[3 + k];
        end
        for (k = 0; k < imageLen; k++) begin
            adr = stim[imageBase + 2 * k];
            dmem[adr[9:0]] = stim[imageBase + 2 * k + 1];
        end
    endtask

    function automatic word_t fetchWord(input word_t adr);
        logic [31:0] offset;
        offset = adr - resetVector;
        if (offset >= progLen) begin
            errorCount++;
            $display("instruction fetch outside the program at %h", adr);
            return '0;
        end
        return imem[offset];
    endfunction

    function automatic word_t readData(input word_t adr);
        if (adr[31:10] != '0) begin
            errorCount++;
            $display("load from %h outside the data memory", adr);
            return ~adr;
        end
        return dmem[adr[9:0]];
    endfunction

    task automatic recordStore(input word_t adr, input word_t dat);
        int idx;
        idx = storeBase + 2 * storeCount;
        if (storeCount >= storeTotal) begin
            errorCount++;
            $display("unexpected store of %h to %h after the last expected store", dat, adr);
        end else begin
            checkStore($sformatf("store %0d", storeCount + 1), stim[idx], stim[idx + 1],
                       adr, dat);
        end
        if (adr[31:10] == '0) begin
            dmem[adr[9:0]] = dat;
        end
        storeCount++;
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // instruction memory with a random wait before each ack
    always @(negedge clk) begin
        if (ackI_i) begin
            ackI_i = 1'b0;
            fetchBusy = 1'b0;
        end else if (stbI_o && !reset) begin
            if (!fetchBusy) begin
                fetchBusy = 1'b1;
                fetchWait = $urandom % (maxWait + 1);
                checkFlag("fetch bus cycle", 1'b1, cycI_o);
            end
            if (fetchWait == 0) begin
                datI_i = fetchWord(adrI_o);
                ackI_i = 1'b1;
            end else begin
                fetchWait--;
            end
        end else begin
            fetchBusy = 1'b0;
        end
    end

    // data memory checks each store when acked
    always @(negedge clk) begin
        if (ackD_i) begin
            ackD_i = 1'b0;
            dataBusy = 1'b0;
        end else if (stbD_o && !reset) begin
            if (!dataBusy) begin
                dataBusy = 1'b1;
                dataWait = $urandom % (maxWait + 1);
                checkFlag("data bus cycle", 1'b1, cycD_o);
                if (storeCount == 0 && !wenD_o) begin
                    errorCount++;
                    $display("data strobe raised for a load at %h before the first store",
                             adrD_o);
                end
            end
            if (dataWait == 0) begin
                if (wenD_o) begin
                    recordStore(adrD_o, datD_o);
                end else begin
                    datD_i = readData(adrD_o);
                end
                ackD_i = 1'b1;
            end else begin
                dataWait--;
            end
        end else begin
            dataBusy = 1'b0;
        end
    end

    initial begin
        wait (stimLoaded);
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: no halt loop reached within %0d cycles", watchdogCycles);
        $display("checks %0d, errors %0d, stores %0d of %0d",
                 checkCount, errorCount, storeCount, storeTotal);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        word_t prevFetch;
        logic  looping;
        void'($urandom(32'h369a));
        reset      = 1'b1;
        datI_i     = '0;
        ackI_i     = 1'b0;
        errI_i     = 1'b0;
        rtyI_i     = 1'b0;
        datD_i     = '0;
        ackD_i     = 1'b0;
        errD_i     = 1'b0;
        rtyD_i     = 1'b0;
        haltReq_i  = 1'b0;
        fetchBusy  = 1'b0;
        dataBusy   = 1'b0;
        storeCount = 0;
        errorCount = 0;
        checkCount = 0;
        loadStim();
        stimLoaded = 1'b1;

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkFlag("fetch strobe after reset", 1'b1, stbI_o);
        checkPc("first fetch address", resetVector, adrI_o);

        // hold the core mid-program
        while (storeCount < 8) @(negedge clk);
        haltReq_i = 1'b1;
        repeat (20) @(negedge clk);
        repeat (10) begin
            @(negedge clk);
            if (stbI_o || stbD_o || cycI_o || cycD_o) begin
                errorCount++;
                $display("bus cycle seen while the halt request was held");
            end
        end
        checkFlag("halt output under halt request", 1'b0, halt_o);
        haltReq_i = 1'b0;

        // run on until the same address is fetched twice in a row
        while (storeCount < storeTotal) @(negedge clk);
        prevFetch = '1;
        looping   = 1'b0;
        while (!looping) begin
            while (!stbI_o) @(negedge clk);
            looping   = (adrI_o == prevFetch);
            prevFetch = adrI_o;
            if (!looping) begin
                while (stbI_o) @(negedge clk);
            end
        end
        checkPc("halt address", stim[storeBase + 2 * storeTotal], adrI_o);

        errD_i = 1'b1;
        @(negedge clk);
        checkFlag("halt on data bus error", 1'b1, halt_o);
        errD_i = 1'b0;
        repeat (2) @(negedge clk);
        repeat (40) begin
            @(negedge clk);
            if (stbI_o || cycI_o) begin
                errorCount++;
                $display("instruction fetch started after the bus error");
            end
        end
        checkFlag("halt held after bus error", 1'b1, halt_o);

        $display("checks %0d, errors %0d, stores %0d of %0d",
                 checkCount, errorCount, storeCount, storeTotal);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tenyrPkg.sv ====
`default_nettype none

package tenyrPkg;

    typedef logic signed [31:0] word_t;
    typedef logic [3:0] regIdx_t;   // 15 aliases the program counter

    typedef enum logic [3:0] {
        opOr   = 4'h0,
        opAnd  = 4'h1,
        opXor  = 4'h2,
        opSra  = 4'h3,
        opAdd  = 4'h4,
        opMul  = 4'h5,
        opEq   = 4'h6,
        opLt   = 4'h7,
        opOrn  = 4'h8,
        opAndn = 4'h9,
        opPack = 4'ha,
        opSrl  = 4'hb,
        opSub  = 4'hc,
        opShl  = 4'hd,
        opTest = 4'he,
        opGe   = 4'hf
    } aluOp_e;

    // named by the A, B, C operand order
    typedef enum logic [1:0] {
        kindXYI    = 2'd0,
        kindXIY    = 2'd1,
        kindIXY    = 2'd2,
        kindZeroXI = 2'd3   // 20-bit immediate
    } insnKind_e;

    typedef enum logic [2:0] {
        stIssue     = 3'd0,
        stExecute   = 3'd1,
        stMemSetup  = 3'd2,
        stMemWait   = 3'd3,
        stWriteBack = 3'd4,
        stFetch     = 3'd5,
        stLatch     = 3'd6
    } coreState_e;

    typedef struct packed {
        insnKind_e kind;
        aluOp_e    op;
        regIdx_t   z;
        regIdx_t   x;
        regIdx_t   y;
        word_t     imm;
        logic      storing;
        logic      loading;
        logic      derefRhs;
        logic      branching;
    } decodedInsn_t;

    typedef struct packed {
        word_t a;
        word_t b;
        word_t c;
    } operands_t;

    typedef struct packed {
        word_t adr;
        word_t dat;
        logic  wen;
        logic  stb;
    } dataBus_t;

endpackage

`default_nettype wire
